// File: include/imul_defines.svh
//------------------------------------------------
// Operand and result width is fixed at 32 bits.
// Shift width must be able to hold the value 32.
//------------------------------------------------

`ifndef IMUL_DEFINES_SVH
`define IMUL_DEFINES_SVH

`define IMUL_NBITS        32
`define IMUL_SHAMT_NBITS  6

`endif

// File: logic/imul_pkg.sv
//------------------------------------------------
// Sequencer state type for the multiplier
//------------------------------------------------

package imul_pkg;

  // One operation in flight, so three states cover it
  typedef enum logic [1:0] {
    IDLE,
    CALC,
    DONE
  } imul_state_t;

endpackage

// File: logic/imul_ctrl_if.sv
//------------------------------------------------
// Control and status between sequencer and datapath.
// No clock inside, all signals are combinational.
//------------------------------------------------

`include "imul_defines.svh"

interface imul_ctrl_if;

  // Control, sequencer to datapath
  logic                          load;
  logic                          acc_clear;
  logic                          acc_en;
  logic [`IMUL_SHAMT_NBITS-1:0]  shift_amt;

  // Status, current multiplier register
  logic [`IMUL_NBITS-1:0]        b_word;

  modport decode  (output load, acc_clear, acc_en, shift_amt, input b_word);

  modport execute (input load, shift_amt, output b_word);

  modport result  (input acc_clear, acc_en);

endinterface

// File: logic/imul_decode.sv
//------------------------------------------------
// Sequencer, one operation at a time.
// Done is seen one cycle after the counter hits 32.
//------------------------------------------------

`include "imul_defines.svh"

module imul_decode (
  input  logic             clk,
  input  logic             reset,

  // Request and response handshake
  input  logic             req_val,
  output logic             req_rdy,
  output logic             resp_val,
  input  logic             resp_rdy,

  imul_ctrl_if.decode      ctrl
);

  localparam int shamt_w = `IMUL_SHAMT_NBITS;

  imul_pkg::imul_state_t  state;
  imul_pkg::imul_state_t  state_next;

  // Bits of the multiplier consumed so far
  logic [shamt_w-1:0]     count;

  logic                   req_go;
  logic                   resp_go;
  logic                   calc_done;
  logic                   step;
  logic [shamt_w-1:0]     shift_dec;

  //------------------------------------------------
  // Handshake and status
  //------------------------------------------------

  assign req_rdy   = (state == imul_pkg::IDLE);
  assign resp_val  = (state == imul_pkg::DONE);
  assign req_go    = req_val && req_rdy;
  assign resp_go   = resp_val && resp_rdy;
  assign calc_done = (count >= `IMUL_NBITS);

  // Working cycle, the last CALC cycle does nothing
  assign step      = (state == imul_pkg::CALC) && !calc_done;

  //------------------------------------------------
  // Zero-skip decoder
  //------------------------------------------------

  // Lowest set bit above bit 0 gives the step size
  // All zero above bit 0 means skip the whole word
  always_comb begin
    shift_dec = shamt_w'(`IMUL_NBITS);
    for (int i = `IMUL_NBITS - 1; i >= 1; i--) begin
      if (ctrl.b_word[i]) begin
        shift_dec = shamt_w'(i);
      end
    end
  end

  //------------------------------------------------
  // State and counter
  //------------------------------------------------

  always_comb begin
    state_next = state;
    case (state)
      imul_pkg::IDLE: if (req_go) state_next = imul_pkg::CALC;
      imul_pkg::CALC: if (calc_done) state_next = imul_pkg::DONE;
      imul_pkg::DONE: if (resp_go) state_next = imul_pkg::IDLE;
      default:        state_next = imul_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imul_pkg::IDLE;
      count <= '0;
    end else begin
      state <= state_next;
      // Counter restarts with each new operation
      if (req_go) begin
        count <= '0;
      end else if (step) begin
        count <= count + ctrl.shift_amt;
      end
    end
  end

  //------------------------------------------------
  // Control outputs
  //------------------------------------------------

  assign ctrl.load      = req_go;
  assign ctrl.acc_clear = req_go;
  assign ctrl.acc_en    = step && ctrl.b_word[0];
  // Registers hold outside working cycles
  assign ctrl.shift_amt = step ? shift_dec : '0;

endmodule

// File: logic/imul_execute.sv
//------------------------------------------------
// Operand registers and shifters.
// Shift of 32 clears a register, which is intended.
//------------------------------------------------

`include "imul_defines.svh"

module imul_execute (
  input  logic                    clk,
  input  logic                    reset,

  // Operands from the request channel
  input  logic [`IMUL_NBITS-1:0]  req_a,
  input  logic [`IMUL_NBITS-1:0]  req_b,

  imul_ctrl_if.execute            ctrl,

  // Multiplicand toward the accumulator
  output logic [`IMUL_NBITS-1:0]  addend
);

  // Multiplicand and multiplier
  logic [`IMUL_NBITS-1:0]  a_reg;
  logic [`IMUL_NBITS-1:0]  b_reg;

  logic [`IMUL_NBITS-1:0]  a_shift;
  logic [`IMUL_NBITS-1:0]  b_shift;

  //------------------------------------------------
  // Shifters
  //------------------------------------------------

  // Multiplicand moves up as multiplier bits are used
  assign a_shift = a_reg << ctrl.shift_amt;
  assign b_shift = b_reg >> ctrl.shift_amt;

  //------------------------------------------------
  // Registers
  //------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      a_reg <= '0;
      b_reg <= '0;
    end else if (ctrl.load) begin
      a_reg <= req_a;
      b_reg <= req_b;
    end else begin
      a_reg <= a_shift;
      b_reg <= b_shift;
    end
  end

  assign ctrl.b_word = b_reg;
  assign addend      = a_reg;

endmodule

// File: logic/imul_result.sv
//------------------------------------------------
// Accumulator, low 32 bits of the product only.
// Sum wraps, carry out is dropped.
//------------------------------------------------

`include "imul_defines.svh"

module imul_result (
  input  logic                    clk,
  input  logic                    reset,

  imul_ctrl_if.result             ctrl,

  // Shifted multiplicand
  input  logic [`IMUL_NBITS-1:0]  addend,

  // Response word
  output logic [`IMUL_NBITS-1:0]  result
);

  logic [`IMUL_NBITS-1:0]  acc;

  // Clear wins over add
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (ctrl.acc_clear) begin
      acc <= '0;
    end else if (ctrl.acc_en) begin
      acc <= acc + addend;
    end
  end

  // Held steady while the response waits
  assign result = acc;

endmodule

// File: logic/imul_top.sv
//------------------------------------------------
// Variable-latency 32-bit unsigned multiplier.
// Low product word only, one operation at a time.
//------------------------------------------------

`include "imul_defines.svh"

module imul_top (
  input  logic                    clk,
  input  logic                    reset,

  // Request channel
  input  logic                    req_val,
  output logic                    req_rdy,
  input  logic [`IMUL_NBITS-1:0]  req_a,
  input  logic [`IMUL_NBITS-1:0]  req_b,

  // Response channel
  output logic                    resp_val,
  input  logic                    resp_rdy,
  output logic [`IMUL_NBITS-1:0]  resp_result
);

  // Shared control and status
  imul_ctrl_if ctrl ();

  // Multiplicand into the accumulator
  logic [`IMUL_NBITS-1:0]  addend;

  //------------------------------------------------
  // Sequencer
  //------------------------------------------------

  imul_decode u_decode (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctrl     (ctrl.decode)
  );

  //------------------------------------------------
  // Datapath
  //------------------------------------------------

  imul_execute u_execute (
    .clk    (clk),
    .reset  (reset),
    .req_a  (req_a),
    .req_b  (req_b),
    .ctrl   (ctrl.execute),
    .addend (addend)
  );

  imul_result u_result (
    .clk    (clk),
    .reset  (reset),
    .ctrl   (ctrl.result),
    .addend (addend),
    .result (resp_result)
  );

endmodule

// File: dv/imul_chk.sv
//------------------------------------------------
// Handshake and sequencer checks, bound into imul_decode.
// Counts its own failures so the testbench can see them.
//------------------------------------------------

module imul_chk (
  input logic                   clk,
  input logic                   reset,
  input logic                   req_val,
  input logic                   req_rdy,
  input logic                   resp_val,
  input logic                   resp_rdy,
  input imul_pkg::imul_state_t  state
);

  // Failed assertions so far
  int fails = 0;

  // Accepted request leaves both channels busy in the next cycle
  a_accept_busy: assert property (@(posedge clk) disable iff (reset)
    req_val && req_rdy |=> !req_rdy && !resp_val)
    else begin
      fails++;
      $error("req_rdy or resp_val high right after an accepted request");
    end

  // Response stays up until it is taken
  a_resp_hold: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val)
    else begin
      fails++;
      $error("resp_val dropped before resp_rdy was seen");
    end

  // Sequencer starts from IDLE
  a_reset_idle: assert property (@(posedge clk) reset |=> state == imul_pkg::IDLE)
    else begin
      fails++;
      $error("sequencer is not in IDLE after reset");
    end

endmodule

bind imul_decode imul_chk u_chk (
  .clk      (clk),
  .reset    (reset),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy),
  .state    (state)
);

// File: dv/imul_tb.sv
//------------------------------------------------
// Table-driven testbench for imul_top.
// Products and step counts come from a model in here.
//------------------------------------------------

`include "imul_defines.svh"

module imul_tb;

  localparam int nbits    = `IMUL_NBITS;
  localparam int n_random = 24;

  logic              clk;
  logic              reset;
  logic              req_val;
  logic              req_rdy;
  logic [nbits-1:0]  req_a;
  logic [nbits-1:0]  req_b;
  logic              resp_val;
  logic              resp_rdy;
  logic [nbits-1:0]  resp_result;

  // Stimulus table, one entry per operation
  logic [nbits-1:0]  tab_a[$];
  logic [nbits-1:0]  tab_b[$];
  logic [nbits-1:0]  tab_prod[$];
  int                tab_steps[$];
  int                tab_hold[$];

  logic [31:0]       lcg_state;
  bit                table_ready;
  int                errors;
  int                passed;

  imul_top UUT (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  always #10 clk = ~clk;

  //------------------------------------------------
  // Random numbers and reference model
  //------------------------------------------------

  // Upper half only, low LCG bits repeat too soon
  function logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[31:16];
  endfunction

  function logic [31:0] rand32();
    return {rand16(), rand16()};
  endfunction

  // Low word of the full 64-bit product
  function automatic logic [31:0] low_product(input logic [31:0] a, input logic [31:0] b);
    logic [63:0] full;
    full = {32'd0, a} * {32'd0, b};
    return full[31:0];
  endfunction

  // Steps taken, each one consumes a bit and the zeros above it
  function automatic int step_count(input logic [31:0] b);
    logic [31:0] w;
    int used;
    int n;
    int s;
    w = b;
    used = 0;
    n = 0;
    while (used < 32) begin
      s = 1;
      while (s < 32 && !w[s]) begin
        s++;
      end
      n++;
      used += s;
      w = (s >= 32) ? 32'd0 : (w >> s);
    end
    return n;
  endfunction

  function void add_entry(input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] prod, input int steps);
    tab_a.push_back(a);
    tab_b.push_back(b);
    tab_prod.push_back(prod);
    tab_steps.push_back(steps);
    // Response stall, 0 to 4 cycles
    tab_hold.push_back(int'(rand16() % 16'd5));
  endfunction

  task log_error(input string msg);
    $display("Fail at time %0t: %s", $time, msg);
    errors++;
  endtask

  //------------------------------------------------
  // Watchdog
  //------------------------------------------------

  initial begin
    wait (table_ready);
    repeat (tab_a.size() * 40 + 10) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", tab_a.size() * 40 + 10);
    $display("Testbench failed");
    $finish;
  end

  //------------------------------------------------
  // Main sequence
  //------------------------------------------------

  initial begin
    int i;
    int h;
    int edges;
    int err_before;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] held;
    clk = 1'b0;
    reset = 1'b1;
    req_val = 1'b0;
    req_a = '0;
    req_b = '0;
    resp_rdy = 1'b0;
    lcg_state = 32'd79708;
    errors = 0;
    passed = 0;
    table_ready = 1'b0;

    // Zero, one, all ones and powers of two
    add_entry(32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 1);
    add_entry(32'h0000_0000, 32'hffff_ffff, 32'h0000_0000, 32);
    add_entry(32'hdead_beef, 32'h0000_0000, 32'h0000_0000, 1);
    add_entry(32'h0000_0001, 32'h9e37_79b9, 32'h9e37_79b9, step_count(32'h9e37_79b9));
    add_entry(32'hcafe_f00d, 32'h0000_0001, 32'hcafe_f00d, 1);
    add_entry(32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001, 32);
    add_entry(32'h0000_0010, 32'h0000_0100, 32'h0000_1000, 2);
    add_entry(32'h8000_0000, 32'h0000_0002, 32'h0000_0000, 2);
    add_entry(32'h0001_0000, 32'h8000_0000, 32'h0000_0000, 2);
    add_entry(32'h0000_0003, 32'h4000_0000, 32'hc000_0000, 2);
    add_entry(32'h1234_5678, 32'h0000_0003, 32'h369d_0368, 2);

    // Random pairs, every third multiplier thinned out
    for (i = 0; i < n_random; i++) begin
      a = rand32();
      b = rand32();
      if (i % 3 == 0) begin
        b = b & rand32() & rand32();
      end
      add_entry(a, b, low_product(a, b), step_count(b));
    end
    table_ready = 1'b1;

    repeat (3) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    if (!req_rdy || resp_val) begin
      log_error("req_rdy low or resp_val high after reset");
    end

    for (i = 0; i < tab_a.size(); i++) begin
      err_before = errors;
      @(posedge clk);
      req_val <= 1'b1;
      req_a <= tab_a[i];
      req_b <= tab_b[i];
      @(negedge clk);
      while (!req_rdy) begin
        @(negedge clk);
      end
      // Acceptance edge, operands must not matter after it
      @(posedge clk);
      req_val <= 1'b0;
      req_a <= ~tab_a[i];
      req_b <= ~tab_b[i];
      edges = 0;
      @(negedge clk);
      while (!resp_val) begin
        if (req_rdy) begin
          log_error($sformatf("req_rdy high while test %0d is busy", i));
        end
        @(posedge clk);
        edges++;
        @(negedge clk);
      end
      if (edges != tab_steps[i] + 1) begin
        log_error($sformatf("test %0d took %0d edges, expected %0d", i, edges,
                            tab_steps[i] + 1));
      end
      if (resp_result !== tab_prod[i]) begin
        log_error($sformatf("test %0d result %h, expected %h", i, resp_result, tab_prod[i]));
      end
      held = resp_result;

      // Stall the response and watch it stay put
      for (h = 0; h < tab_hold[i]; h++) begin
        @(posedge clk);
        @(negedge clk);
        if (!resp_val || resp_result !== held) begin
          log_error($sformatf("test %0d response changed during stall", i));
        end
      end
      @(posedge clk);
      resp_rdy <= 1'b1;
      @(negedge clk);
      if (!resp_val || resp_result !== held) begin
        log_error($sformatf("test %0d response lost before transfer", i));
      end
      // Transfer edge
      @(posedge clk);
      resp_rdy <= 1'b0;
      @(negedge clk);
      if (resp_val || !req_rdy) begin
        log_error($sformatf("test %0d not back in idle after transfer", i));
      end

      if (errors == err_before) begin
        passed++;
      end
      $display("test %0d: a=%h b=%h result=%h edges=%0d hold=%0d %s", i, tab_a[i],
               tab_b[i], held, edges, tab_hold[i], (errors == err_before) ? "ok" : "error");
    end

    // Assertion failures count too
    errors += UUT.u_decode.u_chk.fails;
    $display("%0d tests run, %0d passed, %0d errors", tab_a.size(), passed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
logic/imul_pkg.sv
logic/imul_ctrl_if.sv
logic/imul_decode.sv
logic/imul_execute.sv
logic/imul_result.sv
logic/imul_top.sv
dv/imul_chk.sv
dv/imul_tb.sv

// File: Makefile
# Verilator build and run of the multiplier testbench
TOP = imul_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass message"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	rm -rf obj_dir
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
